//--- hw/spi_pkg.sv
// fixed 8-bit frames and 8 slave selects; changing data_w or num_slaves changes the command layout.
`default_nettype none

package spi_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int data_w = 8;
    localparam int num_slaves = 8;
    localparam int fifo_depth = 4;
    localparam int ss_w = $clog2(num_slaves);
    localparam int div_w = 2;
    localparam int cmd_w = data_w + ss_w + 2 + div_w;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    // two spi_clk edges per bit.
    localparam int edge_w = $clog2(2 * data_w);

    typedef logic [data_w-1:0] spi_byte_t;
    typedef logic [1:0] spi_addr_t;
    typedef logic [ss_w-1:0] ss_index_t;
    typedef logic [div_w-1:0] clk_div_t;
    typedef logic [cmd_w-1:0] spi_cmd_t;
    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
    typedef logic [fifo_ptr_w:0] fifo_cnt_t;

    //////////////////////////////
    // host register map
    //////////////////////////////
    localparam spi_addr_t addr_ctrl = 2'd0;
    localparam spi_addr_t addr_status = 2'd1;
    localparam spi_addr_t addr_tx = 2'd2;
    localparam spi_addr_t addr_rx = 2'd3;

    // control byte fields.
    localparam int ctrl_ss_lsb = 0;
    localparam int ctrl_cpol = 3;
    localparam int ctrl_cpha = 4;
    localparam int ctrl_div_lsb = 5;
    localparam int ctrl_ie = 7;

    // status byte bits.
    localparam int stat_done = 0;
    localparam int stat_overrun = 1;
    localparam int stat_busy = 2;

    // command layout, msb down: tx byte, slave index, cpol, cpha, divider.
    localparam int cmd_div_lsb = 0;
    localparam int cmd_cpha = div_w;
    localparam int cmd_cpol = div_w + 1;
    localparam int cmd_ss_lsb = div_w + 2;
    localparam int cmd_tx_lsb = div_w + 2 + ss_w;

endpackage

`default_nettype wire

//--- hw/spi_host_regs.sv
// single pending tx slot; a tx write while it is busy is dropped, and rx read clears done/overrun.
`timescale 1ns/100ps
`default_nettype none

module spi_host_regs (
    input  wire                     sclk,
    input  wire                     reset,
    input  wire                     cs,
    input  wire                     wr,
    input  wire                     rd,
    input  wire spi_pkg::spi_addr_t addr,
    input  wire spi_pkg::spi_byte_t wdata,
    output spi_pkg::spi_byte_t      rdata,
    output logic                    irq,
    output logic                    cmd_in_req,
    input  wire                     cmd_in_ack,
    output spi_pkg::spi_cmd_t       cmd_in,
    input  wire                     rx_valid,
    input  wire spi_pkg::spi_byte_t rx_byte
);
    import spi_pkg::*;

    spi_byte_t ctrl_reg;
    spi_byte_t rx_reg;
    spi_byte_t status;
    logic      slot_full;
    logic      done;
    logic      overrun;
    logic      ctrl_wr;
    logic      tx_wr;
    logic      rx_rd;
    logic      tx_accept;
    logic      handoff;

    // host bus decode.
    assign ctrl_wr = cs && wr && (addr == addr_ctrl);
    assign tx_wr = cs && wr && (addr == addr_tx);
    assign rx_rd = cs && rd && (addr == addr_rx);
    assign tx_accept = tx_wr && !slot_full;
    assign handoff = cmd_in_req && cmd_in_ack;

    always_ff @(posedge sclk) begin
        if (reset) begin
            ctrl_reg <= '0;
        end else if (ctrl_wr) begin
            ctrl_reg <= wdata;
        end
    end

    //////////////////////////////
    // command producer
    //////////////////////////////

    // slot frees once the fifo has latched it.
    // req waits for ack to fall before it rises again.
    always_ff @(posedge sclk) begin
        if (reset) begin
            slot_full <= 1'b0;
            cmd_in_req <= 1'b0;
        end else if (handoff) begin
            slot_full <= 1'b0;
            cmd_in_req <= 1'b0;
        end else if (tx_accept) begin
            slot_full <= 1'b1;
            cmd_in_req <= !cmd_in_ack;
        end else if (slot_full && !cmd_in_ack) begin
            cmd_in_req <= 1'b1;
        end
    end

    // snapshot of the control byte rides along with the data.
    always_ff @(posedge sclk) begin
        if (tx_accept) begin
            cmd_in[cmd_tx_lsb +: data_w] <= wdata;
            cmd_in[cmd_ss_lsb +: ss_w] <= ctrl_reg[ctrl_ss_lsb +: ss_w];
            cmd_in[cmd_cpol] <= ctrl_reg[ctrl_cpol];
            cmd_in[cmd_cpha] <= ctrl_reg[ctrl_cpha];
            cmd_in[cmd_div_lsb +: div_w] <= ctrl_reg[ctrl_div_lsb +: div_w];
        end
    end

    //////////////////////////////
    // receive side and status
    //////////////////////////////

    // a new byte wins over a same-cycle rx read.
    always_ff @(posedge sclk) begin
        if (reset) begin
            done <= 1'b0;
            overrun <= 1'b0;
        end else if (rx_valid) begin
            done <= 1'b1;
            if (done && !rx_rd) begin
                overrun <= 1'b1;
            end else if (rx_rd) begin
                overrun <= 1'b0;
            end
        end else if (rx_rd) begin
            done <= 1'b0;
            overrun <= 1'b0;
        end
    end

    always_ff @(posedge sclk) begin
        if (rx_valid) begin
            rx_reg <= rx_byte;
        end
    end

    always_comb begin
        status = '0;
        status[stat_done] = done;
        status[stat_overrun] = overrun;
        status[stat_busy] = slot_full;
    end

    // read data holds until the next read.
    always_ff @(posedge sclk) begin
        if (reset) begin
            rdata <= '0;
        end else if (cs && rd) begin
            case (addr)
                addr_ctrl:   rdata <= ctrl_reg;
                addr_status: rdata <= status;
                addr_tx:     rdata <= cmd_in[cmd_tx_lsb +: data_w];
                addr_rx:     rdata <= rx_reg;
            endcase
        end
    end

    assign irq = done && ctrl_reg[ctrl_ie];

endmodule

`default_nettype wire

//--- hw/spi_cmd_fifo.sv
// command queue of fifo_depth entries; four-phase handshakes on both sides, ack held low when full.
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_fifo (
    input  wire                    sclk,
    input  wire                    reset,
    input  wire                    cmd_in_req,
    output logic                   cmd_in_ack,
    input  wire spi_pkg::spi_cmd_t cmd_in,
    output logic                   cmd_out_req,
    input  wire                    cmd_out_ack,
    output spi_pkg::spi_cmd_t      cmd_out
);
    import spi_pkg::*;

    spi_cmd_t  mem [fifo_depth];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      full;
    logic      empty;
    logic      push;
    logic      pop;

    assign full = (count == fifo_cnt_t'(fifo_depth));
    assign empty = (count == '0);

    // one push per req, taken while ack is still low.
    assign push = cmd_in_req && !cmd_in_ack && !full;

    // the head entry leaves when the engine acks it.
    assign pop = cmd_out_req && cmd_out_ack;

    //////////////////////////////
    // input side, slave
    //////////////////////////////
    always_ff @(posedge sclk) begin
        if (reset) begin
            cmd_in_ack <= 1'b0;
        end else if (push) begin
            cmd_in_ack <= 1'b1;
        end else if (!cmd_in_req) begin
            cmd_in_ack <= 1'b0;
        end
    end

    always_ff @(posedge sclk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_in;
        end
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push) begin
            if (wr_ptr == fifo_ptr_t'(fifo_depth - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////
    // output side, master
    //////////////////////////////

    // head entry stays put while req is up, so it is driven straight from memory.
    assign cmd_out = mem[rd_ptr];

    always_ff @(posedge sclk) begin
        if (reset) begin
            cmd_out_req <= 1'b0;
        end else if (pop) begin
            cmd_out_req <= 1'b0;
        end else if (!empty && !cmd_out_ack) begin
            cmd_out_req <= 1'b1;
        end
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            if (rd_ptr == fifo_ptr_t'(fifo_depth - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy.
    always_ff @(posedge sclk) begin
        if (reset) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_shift_engine.sv
// 8-bit msb-first frames in all four modes; spi_clk half period is 2*div+2 sclk cycles, one slave.
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine (
    input  wire                             sclk,
    input  wire                             reset,
    input  wire                             cmd_out_req,
    output logic                            cmd_out_ack,
    input  wire spi_pkg::spi_cmd_t          cmd_out,
    output logic                            rx_valid,
    output spi_pkg::spi_byte_t              rx_byte,
    output logic                            spi_clk,
    output logic                            mosi,
    input  wire                             miso,
    output logic [spi_pkg::num_slaves-1:0]  ss
);
    import spi_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_setup,
        s_shift,
        s_hold
    } state_t;

    state_t           state;
    spi_byte_t        cmd_tx;
    ss_index_t        cmd_sel;
    clk_div_t         cmd_div;
    logic             cmd_pol;
    logic             cmd_pha;
    clk_div_t         div_code;
    logic             cpha;
    logic [div_w:0]   half_cnt;
    logic [edge_w-1:0] edge_cnt;
    spi_byte_t        tx_shift;
    logic             start;
    logic             tick;
    logic             leading;
    logic             sample;

    // command fields.
    assign cmd_tx = cmd_out[cmd_tx_lsb +: data_w];
    assign cmd_sel = cmd_out[cmd_ss_lsb +: ss_w];
    assign cmd_div = cmd_out[cmd_div_lsb +: div_w];
    assign cmd_pol = cmd_out[cmd_cpol];
    assign cmd_pha = cmd_out[cmd_cpha];

    // a new command is taken only from idle.
    assign start = (state == s_idle) && cmd_out_req && !cmd_out_ack;

    // tick ends each half period of spi_clk.
    assign tick = (state != s_idle) && (half_cnt == '0);

    // odd edges (even count before the edge) lead.
    assign leading = !edge_cnt[0];

    // cpha 0 samples on leading edges, cpha 1 on trailing ones.
    assign sample = leading ^ cpha;

    always_ff @(posedge sclk) begin
        if (reset) begin
            cmd_out_ack <= 1'b0;
        end else if (start) begin
            cmd_out_ack <= 1'b1;
        end else if (!cmd_out_req) begin
            cmd_out_ack <= 1'b0;
        end
    end

    //////////////////////////////
    // frame sequencer
    //////////////////////////////

    // setup is the half period between ss low and the first edge.
    // hold is the half period after edge 16, then ss rises.
    always_ff @(posedge sclk) begin
        if (reset) begin
            state <= s_idle;
            spi_clk <= 1'b0;
            mosi <= 1'b0;
            ss <= '1;
            rx_valid <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_setup;
                        spi_clk <= cmd_pol;
                        ss <= ~(num_slaves'(1) << cmd_sel);
                        half_cnt <= {cmd_div, 1'b1};
                        edge_cnt <= '0;
                        // cpha 0 needs the first bit out before the first edge.
                        if (!cmd_pha) begin
                            mosi <= cmd_tx[data_w-1];
                        end
                    end
                end
                s_setup, s_shift: begin
                    if (tick) begin
                        spi_clk <= !spi_clk;
                        half_cnt <= {div_code, 1'b1};
                        edge_cnt <= edge_cnt + 1'b1;
                        if (!sample) begin
                            mosi <= tx_shift[data_w-1];
                        end
                        if (edge_cnt == edge_w'(2 * data_w - 1)) begin
                            state <= s_hold;
                        end else begin
                            state <= s_shift;
                        end
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                end
                s_hold: begin
                    if (tick) begin
                        ss <= '1;
                        rx_valid <= 1'b1;
                        state <= s_idle;
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    //////////////////////////////
    // shift registers
    //////////////////////////////
    always_ff @(posedge sclk) begin
        if (start) begin
            div_code <= cmd_div;
            cpha <= cmd_pha;
            // for cpha 0 bit 7 already went out at start.
            tx_shift <= cmd_pha ? cmd_tx : {cmd_tx[data_w-2:0], 1'b0};
        end else if (tick && (state != s_hold)) begin
            if (sample) begin
                rx_byte <= {rx_byte[data_w-2:0], miso};
            end else begin
                tx_shift <= {tx_shift[data_w-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_master_top.sv
// host register port plus spi pins; one slave selected per frame, frames run back to back from the queue.
`timescale 1ns/100ps
`default_nettype none

module spi_master_top (
    input  wire                             sclk,
    input  wire                             reset,
    input  wire                             cs,
    input  wire                             wr,
    input  wire                             rd,
    input  wire spi_pkg::spi_addr_t         addr,
    input  wire spi_pkg::spi_byte_t         wdata,
    output wire spi_pkg::spi_byte_t         rdata,
    output wire                             irq,
    output wire                             spi_clk,
    output wire                             mosi,
    input  wire                             miso,
    output wire [spi_pkg::num_slaves-1:0]   ss
);
    import spi_pkg::*;

    // register block to fifo.
    wire           cmd_in_req;
    wire           cmd_in_ack;
    wire spi_cmd_t cmd_in;

    // fifo to shift engine.
    wire           cmd_out_req;
    wire           cmd_out_ack;
    wire spi_cmd_t cmd_out;

    // received byte strobe back to the registers.
    wire            rx_valid;
    wire spi_byte_t rx_byte;

    spi_host_regs i_regs (
        .sclk       (sclk),
        .reset      (reset),
        .cs         (cs),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .irq        (irq),
        .cmd_in_req (cmd_in_req),
        .cmd_in_ack (cmd_in_ack),
        .cmd_in     (cmd_in),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte)
    );

    spi_cmd_fifo i_fifo (
        .sclk        (sclk),
        .reset       (reset),
        .cmd_in_req  (cmd_in_req),
        .cmd_in_ack  (cmd_in_ack),
        .cmd_in      (cmd_in),
        .cmd_out_req (cmd_out_req),
        .cmd_out_ack (cmd_out_ack),
        .cmd_out     (cmd_out)
    );

    spi_shift_engine i_engine (
        .sclk        (sclk),
        .reset       (reset),
        .cmd_out_req (cmd_out_req),
        .cmd_out_ack (cmd_out_ack),
        .cmd_out     (cmd_out),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .spi_clk     (spi_clk),
        .mosi        (mosi),
        .miso        (miso),
        .ss          (ss)
    );

endmodule

`default_nettype wire

//--- verification/spi_slave_model.sv
// behavioral slave; mode comes from cpol/cpha inputs, reply is latched 1 ns after ss falls.
`timescale 1ns/100ps
`default_nettype none

module spi_slave_model (
    input  wire                             spi_clk,
    input  wire                             mosi,
    output logic                            miso,
    input  wire [spi_pkg::num_slaves-1:0]   ss,
    input  wire                             cpol,
    input  wire                             cpha,
    input  wire spi_pkg::spi_byte_t         reply,
    output spi_pkg::spi_byte_t              rx_data,
    output int                              rx_count
);
    import spi_pkg::*;

    wire       selected;
    spi_byte_t tx;
    spi_byte_t rx;
    int        out_idx;
    logic      rising;

    assign selected = ~&ss;

    //////////////////////////////
    // one frame per select pulse
    //////////////////////////////
    initial begin
        miso = 1'b0;
        rx_data = '0;
        rx_count = 0;
        forever begin
            @(posedge selected);
            // skip the cpol settle edge that starts with ss.
            #1;
            tx = reply;
            rx = '0;
            out_idx = data_w - 1;
            // cpha 0 needs bit 7 before the first edge.
            if (!cpha) begin
                miso = tx[out_idx];
                out_idx = out_idx - 1;
            end
            repeat (2 * data_w) begin
                @(spi_clk);
                rising = spi_clk;
                // capture edge is rising when cpol equals cpha.
                if (rising == (cpol == cpha)) begin
                    rx = {rx[data_w-2:0], mosi};
                end else if (out_idx >= 0) begin
                    miso = tx[out_idx];
                    out_idx = out_idx - 1;
                end
            end
            rx_data = rx;
            rx_count = rx_count + 1;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_spi_master.sv
// testbench for spi_master_top; polls status for done, one slave model on all ss lines.
`timescale 1ns/100ps
`default_nettype none

module tb_spi_master;
    import spi_pkg::*;

    localparam int clk_period = 40;
    localparam int num_frames = 12;
    // slowest divider, 18 half periods of 8 cycles.
    localparam int frame_ns = (2 * data_w + 2) * 8 * clk_period;
    localparam int timeout_ns = num_frames * frame_ns + 40000;

    logic           sclk;
    logic           reset;
    logic           cs;
    logic           wr;
    logic           rd;
    spi_addr_t      addr;
    spi_byte_t      wdata;
    wire spi_byte_t rdata;
    wire            irq;
    wire            spi_clk;
    wire            mosi;
    wire            miso;
    wire [num_slaves-1:0] ss;

    logic           slave_cpol;
    logic           slave_cpha;
    spi_byte_t      slave_reply;
    wire spi_byte_t slave_rx;
    int             slave_count;

    int             errors;
    int             seed;
    logic [num_slaves-1:0] low_mask;
    time            last_edge;
    time            half_meas;
    spi_byte_t      seen[$];

    spi_master_top i_dut (
        .sclk    (sclk),
        .reset   (reset),
        .cs      (cs),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .irq     (irq),
        .spi_clk (spi_clk),
        .mosi    (mosi),
        .miso    (miso),
        .ss      (ss)
    );

    spi_slave_model i_slave (
        .spi_clk  (spi_clk),
        .mosi     (mosi),
        .miso     (miso),
        .ss       (ss),
        .cpol     (slave_cpol),
        .cpha     (slave_cpha),
        .reply    (slave_reply),
        .rx_data  (slave_rx),
        .rx_count (slave_count)
    );

    initial begin
        sclk = 1'b0;
    end

    always #(clk_period / 2) sclk = ~sclk;

    //////////////////////////////
    // pin monitors
    //////////////////////////////
    always @(ss) begin
        low_mask = low_mask | ~ss;
    end

    // the last interval of a frame is one clean half period.
    always @(spi_clk) begin
        if (~&ss) begin
            half_meas = $time - last_edge;
            last_edge = $time;
        end
    end

    always @(slave_count) begin
        #1;
        seen.push_back(slave_rx);
    end

    initial begin
        #(timeout_ns);
        $display("run timed out after %0d ns", timeout_ns);
        $display("test failed");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // expected {ss low mask, status, rx byte} after a frame with no rx read.
    function automatic logic [23:0] expect_frame(input spi_byte_t ctrl, input spi_byte_t reply,
                                                 input logic prior_done);
        logic [num_slaves-1:0] ss_low;
        spi_byte_t             status;
        ss_low = num_slaves'(1) << ctrl[ctrl_ss_lsb +: ss_w];
        status = '0;
        status[stat_done] = 1'b1;
        status[stat_overrun] = prior_done;
        return {ss_low, status, reply};
    endfunction

    task automatic write_reg(input spi_addr_t a, input spi_byte_t d);
        @(posedge sclk);
        cs <= 1'b1;
        wr <= 1'b1;
        addr <= a;
        wdata <= d;
        @(posedge sclk);
        cs <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic read_reg(input spi_addr_t a, output spi_byte_t d);
        @(posedge sclk);
        cs <= 1'b1;
        rd <= 1'b1;
        addr <= a;
        @(posedge sclk);
        cs <= 1'b0;
        rd <= 1'b0;
        @(negedge sclk);
        d = rdata;
    endtask

    task automatic wait_status(input spi_byte_t mask);
        spi_byte_t st;
        int        polls;
        st = '0;
        for (polls = 0; polls < 500 && (st & mask) == 0; polls++) begin
            read_reg(addr_status, st);
        end
        if ((st & mask) == 0) begin
            $display("status bits %0h never set at %0t ns", mask, $time);
            errors++;
        end
    endtask

    task automatic set_slave(input spi_byte_t ctrl, input spi_byte_t reply);
        @(posedge sclk);
        slave_cpol <= ctrl[ctrl_cpol];
        slave_cpha <= ctrl[ctrl_cpha];
        slave_reply <= reply;
    endtask

    //////////////////////////////
    // test cases
    //////////////////////////////

    // mode and divider both follow code; odd codes enable irq.
    task automatic run_mode(input int code);
        spi_byte_t   ctrl;
        spi_byte_t   tx;
        spi_byte_t   reply;
        spi_byte_t   got;
        logic [23:0] exp;
        ctrl = '0;
        ctrl[ctrl_ss_lsb +: ss_w] = ss_index_t'(2 * code + 1);
        ctrl[ctrl_cpol] = code[1];
        ctrl[ctrl_cpha] = code[0];
        ctrl[ctrl_div_lsb +: div_w] = clk_div_t'(code);
        ctrl[ctrl_ie] = code[0];
        tx = spi_byte_t'($random(seed));
        reply = spi_byte_t'($random(seed));
        exp = expect_frame(ctrl, reply, 1'b0);
        set_slave(ctrl, reply);
        write_reg(addr_ctrl, ctrl);
        low_mask = '0;
        write_reg(addr_tx, tx);
        wait_status(spi_byte_t'(1 << stat_done));
        compare_value("ss low mask", low_mask, exp[23:16]);
        compare_value("spi_clk half period", half_meas, (2 * code + 2) * clk_period);
        compare_value("spi_clk rest level", spi_clk, ctrl[ctrl_cpol]);
        compare_value("irq", irq, ctrl[ctrl_ie]);
        compare_value("slave mosi byte", seen[$], tx);
        read_reg(addr_status, got);
        compare_value("status", got, exp[15:8]);
        read_reg(addr_rx, got);
        compare_value("rx", got, exp[7:0]);
        read_reg(addr_status, got);
        compare_value("status after rx read", got, 0);
        compare_value("irq after rx read", irq, 0);
    endtask

    task automatic run_overrun();
        spi_byte_t   ctrl;
        spi_byte_t   reply;
        spi_byte_t   got;
        logic [23:0] exp;
        ctrl = 8'h80 | (8'd1 << ctrl_div_lsb) | 8'd6;
        reply = spi_byte_t'($random(seed));
        set_slave(ctrl, reply);
        write_reg(addr_ctrl, ctrl);
        write_reg(addr_tx, spi_byte_t'($random(seed)));
        wait_status(spi_byte_t'(1 << stat_done));
        reply = spi_byte_t'($random(seed));
        exp = expect_frame(ctrl, reply, 1'b1);
        set_slave(ctrl, reply);
        write_reg(addr_tx, spi_byte_t'($random(seed)));
        wait_status(spi_byte_t'(1 << stat_overrun));
        read_reg(addr_status, got);
        compare_value("status with overrun", got, exp[15:8]);
        read_reg(addr_rx, got);
        compare_value("rx after overrun", got, exp[7:0]);
        read_reg(addr_status, got);
        compare_value("status after rx read", got, 0);
    endtask

    // engine takes one, fifo holds four, slot holds one, the next is dropped.
    task automatic run_burst();
        spi_byte_t ctrl;
        spi_byte_t got;
        spi_byte_t tx[6];
        int        base;
        int        n;
        ctrl = 8'd3 << ctrl_div_lsb | 8'd4;
        base = seen.size();
        set_slave(ctrl, 8'h5a);
        write_reg(addr_ctrl, ctrl);
        for (n = 0; n < 6; n++) begin
            tx[n] = spi_byte_t'($random(seed));
            write_reg(addr_tx, tx[n]);
            repeat (2) @(posedge sclk);
        end
        read_reg(addr_status, got);
        compare_value("status busy before extra write", got[stat_busy], 1'b1);
        write_reg(addr_tx, spi_byte_t'($random(seed)));
        read_reg(addr_status, got);
        compare_value("status busy after extra write", got[stat_busy], 1'b1);
        for (n = 0; n < 8 * frame_ns / clk_period && seen.size() < base + 6; n++) begin
            @(posedge sclk);
        end
        if (seen.size() < base + 6) begin
            $display("burst frames did not all reach the slave");
            errors++;
        end
        repeat (400) @(posedge sclk);
        compare_value("burst frame count", seen.size() - base, 6);
        for (n = 0; n < 6 && base + n < seen.size(); n++) begin
            compare_value("burst mosi byte", seen[base + n], tx[n]);
        end
        read_reg(addr_rx, got);
        read_reg(addr_status, got);
        compare_value("status after burst", got, 0);
    endtask

    initial begin
        spi_byte_t got;
        int        code;
        cs = 1'b0;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        slave_cpol = 1'b0;
        slave_cpha = 1'b0;
        slave_reply = '0;
        errors = 0;
        seed = 32'h8cb754ec;
        low_mask = '0;
        last_edge = 0;
        half_meas = 0;
        reset = 1'b1;
        repeat (2) @(posedge sclk);
        reset <= 1'b0;

        compare_value("ss after reset", ss, {num_slaves{1'b1}});
        compare_value("irq after reset", irq, 0);
        read_reg(addr_status, got);
        compare_value("status after reset", got, 0);

        for (code = 0; code < 4; code++) begin
            run_mode(code);
        end
        run_overrun();
        run_burst();

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/spi_pkg.sv
hw/spi_host_regs.sv
hw/spi_cmd_fifo.sv
hw/spi_shift_engine.sv
hw/spi_master_top.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI master testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_spi_master \
    -f files.f \
    -o sim_tb_spi_master

./obj_dir/sim_tb_spi_master > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
fi
exit 1
